/* source/stream_pkg.sv */
`default_nettype none

package stream_pkg;

  // One byte of the input and output streams
  typedef logic [7:0] byte_t;

  // A FIFO entry holds the last flag above the data byte
  typedef logic [$bits(byte_t):0] word_t;

  // CRC-8 generator x^8 + x^2 + x + 1, MSB first, initial value zero
  localparam byte_t CRC_POLY = 8'h07;

  // The FIFO level has no typedef here
  // Its width is $clog2(DEPTH) + 1 and follows the DEPTH parameter of each user

endpackage

`default_nettype wire

/* source/link_ctrl_pkg.sv */
`default_nettype none

package link_ctrl_pkg;

  // Link controller states
  typedef enum logic [1:0] {
    IDLE,
    SEND,
    WAIT_ACK
  } link_state_t;

  // Number of naks seen for the frame in flight
  typedef logic [3:0] retry_t;

endpackage

`default_nettype wire

/* source/crc8_check.sv */
`timescale 1ns/1ps
`default_nettype none

module crc8_check
  import stream_pkg::*;
(
  input  wire        clock,
  input  wire        reset,

  input  wire        valid_i,
  input  wire        ready_i,
  input  wire        keep_i,
  input  wire        last_i,
  input  wire byte_t data_i,

  output logic       save_o,
  output logic       drop_o
);

  byte_t crc_q;
  byte_t crc_next;
  byte_t crc_final;
  logic  xfer;

  // One byte through the bitwise CRC-8 shift register
  function automatic byte_t crc8_step(input byte_t crc, input byte_t data);
    byte_t  c;
    integer i;
    c = crc ^ data;
    for (i = 0; i < 8; i++) begin
      c = c[7] ? ((c << 1) ^ CRC_POLY) : (c << 1);
    end
    return c;
  endfunction

  assign xfer      = valid_i && ready_i;
  assign crc_next  = crc8_step(crc_q, data_i);

  // Dropped beats do not enter the checksum
  assign crc_final = keep_i ? crc_next : crc_q;

  // Residue over payload plus trailer is zero for a good frame
  assign save_o = xfer && last_i && (crc_final == '0);
  assign drop_o = xfer && last_i && (crc_final != '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      crc_q <= '0;
    end else if (xfer) begin
      if (last_i) begin
        crc_q <= '0;
      end else if (keep_i) begin
        crc_q <= crc_next;
      end
    end
  end

  // A beat waiting for ready must reach the checksum unchanged
  assert property (@(posedge clock) disable iff (reset)
    (valid_i && !ready_i) |=> (valid_i && $stable({keep_i, last_i, data_i})))
    else $error("crc8_check: input beat changed while waiting for ready");

endmodule

`default_nettype wire

/* source/packet_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_fifo
  import stream_pkg::*;
#(
  parameter int DEPTH = 32
) (
  input  wire                     clock,
  input  wire                     reset,

  output logic [$clog2(DEPTH):0]  level_o,

  input  wire                     save_i,
  input  wire                     drop_i,
  input  wire                     redo_i,
  input  wire                     next_i,

  input  wire                     s_tvalid_i,
  output logic                    s_tready_o,
  input  wire                     s_tkeep_i,
  input  wire                     s_tlast_i,
  input  wire byte_t              s_tdata_i,

  output logic                    m_tvalid_o,
  input  wire                     m_tready_i,
  output logic                    m_tlast_o,
  output byte_t                   m_tdata_o
);

  localparam int ABITS = $clog2(DEPTH);

  // Pointers carry one wrap bit above the address
  typedef logic [ABITS:0]   ptr_t;
  typedef logic [ABITS-1:0] addr_t;

  word_t mem [DEPTH];

  // wr_ptr runs ahead on the write side
  ptr_t wr_ptr;
  // cm_ptr marks the end of committed frames
  ptr_t cm_ptr;
  // rd_ptr fetches on the read side
  ptr_t rd_ptr;
  // rp_ptr marks the start of the frame in flight
  ptr_t rp_ptr;

  ptr_t wr_next;
  ptr_t cm_next;
  ptr_t rd_next;
  ptr_t rp_next;
  ptr_t level_q;

  logic ready_q;
  logic store;
  logic fetch;
  logic full_next;

  // Beats with keep low are accepted but never written
  assign store = s_tvalid_i && ready_q && s_tkeep_i;
  assign fetch = m_tvalid_o && m_tready_i;

  always_comb begin
    wr_next = wr_ptr;
    if (drop_i) begin
      // Discard the whole uncommitted frame including this beat
      wr_next = cm_ptr;
    end else if (store) begin
      wr_next = wr_ptr + 1'b1;
    end
  end

  always_comb begin
    cm_next = cm_ptr;
    if (save_i) begin
      cm_next = store ? wr_ptr + 1'b1 : wr_ptr;
    end
  end

  always_comb begin
    rd_next = rd_ptr;
    if (redo_i) begin
      rd_next = rp_ptr;
    end else if (fetch) begin
      rd_next = rd_ptr + 1'b1;
    end
  end

  always_comb begin
    rp_next = rp_ptr;
    if (next_i) begin
      rp_next = rd_ptr;
    end
  end

  // Space is held until the frame in flight is acked rather than just read
  assign full_next = (wr_next - rp_next) == ptr_t'(DEPTH);

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr  <= '0;
      cm_ptr  <= '0;
      rd_ptr  <= '0;
      rp_ptr  <= '0;
      ready_q <= 1'b0;
      level_q <= '0;
    end else begin
      wr_ptr  <= wr_next;
      cm_ptr  <= cm_next;
      rd_ptr  <= rd_next;
      rp_ptr  <= rp_next;
      ready_q <= !full_next;
      level_q <= cm_next - rd_next;
    end
  end

  always_ff @(posedge clock) begin
    if (store) begin
      mem[addr_t'(wr_ptr)] <= {s_tlast_i, s_tdata_i};
    end
  end

  // Reads are asynchronous so that a replay never sees a stale prefetch
  assign {m_tlast_o, m_tdata_o} = mem[addr_t'(rd_ptr)];

  // Only committed beats are visible
  assign m_tvalid_o = rd_ptr != cm_ptr;

  assign s_tready_o = ready_q;
  assign level_o    = level_q;

  // Replay, read, committed and write pointers stay in order and never overfill
  assert property (@(posedge clock) disable iff (reset)
    ((rd_ptr - rp_ptr) <= (cm_ptr - rp_ptr)) &&
    ((cm_ptr - rp_ptr) <= (wr_ptr - rp_ptr)) &&
    ((wr_ptr - rp_ptr) <= ptr_t'(DEPTH)))
    else $error("packet_fifo: pointers out of order or FIFO overfilled");

  // The controller resolves a frame either by advancing or by replaying
  assert property (@(posedge clock) disable iff (reset) !(redo_i && next_i))
    else $error("packet_fifo: redo and next asserted together");

endmodule

`default_nettype wire

/* source/link_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module link_ctrl
  import link_ctrl_pkg::*;
#(
  parameter int MAX_RETRIES = 3
) (
  input  wire  clock,
  input  wire  reset,

  // FIFO read side
  input  wire  f_tvalid_i,
  output logic f_tready_o,
  input  wire  f_tlast_i,

  // Outgoing link
  output logic m_tvalid_o,
  input  wire  m_tready_i,

  // Far end response
  input  wire  ack_i,
  input  wire  nak_i,

  output logic next_o,
  output logic redo_o,
  output logic abort_o
);

  link_state_t state_q;
  link_state_t state_d;
  retry_t      retry_q;
  retry_t      retry_d;
  logic        last_xfer;

  assign last_xfer = (state_q == SEND) && f_tvalid_i && m_tready_i && f_tlast_i;

  always_comb begin
    state_d    = state_q;
    retry_d    = retry_q;
    m_tvalid_o = 1'b0;
    f_tready_o = 1'b0;
    next_o     = 1'b0;
    redo_o     = 1'b0;
    abort_o    = 1'b0;

    case (state_q)
      IDLE: begin
        // Wait for a committed frame or for a replay to reload the pointer
        if (f_tvalid_i) begin
          state_d = SEND;
        end
      end

      SEND: begin
        m_tvalid_o = f_tvalid_i;
        f_tready_o = m_tready_i;
        if (last_xfer) begin
          state_d = WAIT_ACK;
        end
      end

      WAIT_ACK: begin
        if (ack_i) begin
          next_o  = 1'b1;
          retry_d = '0;
          state_d = IDLE;
        end else if (nak_i) begin
          if (retry_q == retry_t'(MAX_RETRIES)) begin
            // Out of retries so the frame is given up
            next_o  = 1'b1;
            abort_o = 1'b1;
            retry_d = '0;
          end else begin
            redo_o  = 1'b1;
            retry_d = retry_q + 1'b1;
          end
          state_d = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= IDLE;
      retry_q <= '0;
    end else begin
      state_q <= state_d;
      retry_q <= retry_d;
    end
  end

  // Once offered, a beat stays valid on the link until it is taken
  assert property (@(posedge clock) disable iff (reset)
    (m_tvalid_o && !m_tready_i) |=> m_tvalid_o)
    else $error("link_ctrl: m_tvalid_o dropped before the beat was taken");

endmodule

`default_nettype wire

/* source/packet_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_link_top
  import stream_pkg::*;
#(
  parameter int DEPTH       = 32,
  parameter int MAX_RETRIES = 3
) (
  input  wire                     clock,
  input  wire                     reset,

  input  wire                     s_tvalid_i,
  output logic                    s_tready_o,
  input  wire                     s_tkeep_i,
  input  wire                     s_tlast_i,
  input  wire byte_t              s_tdata_i,

  output logic                    m_tvalid_o,
  input  wire                     m_tready_i,
  output logic                    m_tlast_o,
  output byte_t                   m_tdata_o,

  input  wire                     ack_i,
  input  wire                     nak_i,
  output logic                    abort_o,

  output logic [$clog2(DEPTH):0]  level_o
);

  logic save;
  logic drop;
  logic redo;
  logic next;
  logic fifo_tvalid;
  logic fifo_tready;

  // Checker snoops the same handshake the FIFO accepts on
  crc8_check u_crc8_check (
    .clock   (clock),
    .reset   (reset),
    .valid_i (s_tvalid_i),
    .ready_i (s_tready_o),
    .keep_i  (s_tkeep_i),
    .last_i  (s_tlast_i),
    .data_i  (s_tdata_i),
    .save_o  (save),
    .drop_o  (drop)
  );

  packet_fifo #(
    .DEPTH (DEPTH)
  ) u_packet_fifo (
    .clock      (clock),
    .reset      (reset),
    .level_o    (level_o),
    .save_i     (save),
    .drop_i     (drop),
    .redo_i     (redo),
    .next_i     (next),
    .s_tvalid_i (s_tvalid_i),
    .s_tready_o (s_tready_o),
    .s_tkeep_i  (s_tkeep_i),
    .s_tlast_i  (s_tlast_i),
    .s_tdata_i  (s_tdata_i),
    .m_tvalid_o (fifo_tvalid),
    .m_tready_i (fifo_tready),
    .m_tlast_o  (m_tlast_o),
    .m_tdata_o  (m_tdata_o)
  );

  // Data and last go straight out, only the handshake is gated
  link_ctrl #(
    .MAX_RETRIES (MAX_RETRIES)
  ) u_link_ctrl (
    .clock      (clock),
    .reset      (reset),
    .f_tvalid_i (fifo_tvalid),
    .f_tready_o (fifo_tready),
    .f_tlast_i  (m_tlast_o),
    .m_tvalid_o (m_tvalid_o),
    .m_tready_i (m_tready_i),
    .ack_i      (ack_i),
    .nak_i      (nak_i),
    .next_o     (next),
    .redo_o     (redo),
    .abort_o    (abort_o)
  );

endmodule

`default_nettype wire

/* test/tb_packet_link.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_packet_link
  import stream_pkg::*;
();

  localparam int  DEPTH       = 8;
  localparam int  MAX_RETRIES = 3;
  localparam int  LW          = $clog2(DEPTH) + 1;
  localparam int  MAX_RECS    = 256;
  localparam time DRIVE_DELAY = 10;

  logic          clock;
  logic          reset;
  logic          s_tvalid_i;
  logic          s_tready_o;
  logic          s_tkeep_i;
  logic          s_tlast_i;
  byte_t         s_tdata_i;
  logic          m_tvalid_o;
  logic          m_tready_i;
  logic          m_tlast_o;
  byte_t         m_tdata_o;
  logic          ack_i;
  logic          nak_i;
  logic          abort_o;
  logic [LW-1:0] level_o;

  // Record layout is opcode, flags, byte in four, four and eight bits
  logic [15:0] recs [MAX_RECS];
  logic [8:0]  out_q [$];
  string       names [7];
  integer      seed = 13282;
  logic        stall;
  int          n_rec;
  int          limit = 0;
  int          cycles;
  int          test_idx;
  int          checks;
  int          errors;
  int          test_errors;
  int          failed_tests;

  packet_link_top #(
    .DEPTH       (DEPTH),
    .MAX_RETRIES (MAX_RETRIES)
  ) DUT (
    .clock      (clock),
    .reset      (reset),
    .s_tvalid_i (s_tvalid_i),
    .s_tready_o (s_tready_o),
    .s_tkeep_i  (s_tkeep_i),
    .s_tlast_i  (s_tlast_i),
    .s_tdata_i  (s_tdata_i),
    .m_tvalid_o (m_tvalid_o),
    .m_tready_i (m_tready_i),
    .m_tlast_o  (m_tlast_o),
    .m_tdata_o  (m_tdata_o),
    .ack_i      (ack_i),
    .nak_i      (nak_i),
    .abort_o    (abort_o),
    .level_o    (level_o)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Output side ready, either random or held low to build up the FIFO
  initial begin
    forever begin
      @(posedge clock);
      #DRIVE_DELAY;
      m_tready_i = stall ? 1'b0 : (($random(seed) & 3) != 0);
    end
  end

  // Inputs settle by the falling edge, so words are captured there
  always @(negedge clock) begin
    if (!reset && m_tvalid_o && m_tready_i) begin
      out_q.push_back({m_tlast_o, m_tdata_o});
    end
  end

  initial begin
    cycles = 0;
    wait (limit != 0);
    while (cycles < limit) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Some tests failed");
    $finish;
  end

  task automatic step();
    @(posedge clock);
    #DRIVE_DELAY;
  endtask

  task automatic compare_value(input string what, input int expected, input int actual);
    checks++;
    assert (expected == actual) else begin
      $display("MISMATCH %s %s: expected %0h, actual %0h",
               names[test_idx], what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      $display("test %0d %s: ok", test_idx, names[test_idx]);
    end else begin
      $display("test %0d %s: %0d error(s)", test_idx, names[test_idx], test_errors);
      failed_tests++;
    end
    test_errors = 0;
    test_idx++;
  endtask

  // Holds the beat until s_tready_o is seen high before an edge
  task automatic send_beat(input logic keep, input logic last, input byte_t data);
    logic done;
    s_tvalid_i = 1'b1;
    s_tkeep_i  = keep;
    s_tlast_i  = last;
    s_tdata_i  = data;
    done       = 1'b0;
    while (!done) begin
      @(negedge clock);
      done = s_tready_o;
      step();
    end
    s_tvalid_i = 1'b0;
  endtask

  task automatic expect_word(input logic last, input byte_t data);
    logic [8:0] got;
    while (out_q.size() == 0) begin
      step();
    end
    got = out_q.pop_front();
    compare_value("output word", int'({last, data}), int'(got));
  endtask

  // One cycle ack or nak pulse, abort is sampled while it is held
  task automatic respond(input logic is_nak, input logic abort_exp);
    ack_i = !is_nak;
    nak_i = is_nak;
    @(negedge clock);
    compare_value(is_nak ? "abort_o on nak" : "abort_o on ack", int'(abort_exp),
                  int'(abort_o));
    step();
    ack_i = 1'b0;
    nak_i = 1'b0;
  endtask

  task automatic expect_level(input logic ready_exp, input byte_t level_exp);
    compare_value("level_o", int'(level_exp), int'(level_o));
    compare_value("s_tready_o", int'(ready_exp), int'(s_tready_o));
  endtask

  initial begin
    logic [3:0] op;
    logic [3:0] flags;
    byte_t      data;
    reset      = 1'b1;
    s_tvalid_i = 1'b0;
    s_tkeep_i  = 1'b0;
    s_tlast_i  = 1'b0;
    s_tdata_i  = '0;
    m_tready_i = 1'b0;
    ack_i      = 1'b0;
    nak_i      = 1'b0;
    stall      = 1'b0;
    names[0] = "reset_values";
    names[1] = "good_frame";
    names[2] = "bad_crc_drop";
    names[3] = "keep_filter";
    names[4] = "nak_replay";
    names[5] = "retry_abort";
    names[6] = "full_level";
    for (int i = 0; i < MAX_RECS; i++) begin
      recs[i] = '0;
    end
    $readmemh("test/link_patterns.mem", recs);
    n_rec = 0;
    while (n_rec < MAX_RECS && recs[n_rec][15:12] != 4'h0) begin
      n_rec++;
    end
    limit = 40 * n_rec + 20;

    repeat (2) @(posedge clock);
    @(negedge clock);
    compare_value("s_tready_o in reset", 0, int'(s_tready_o));
    compare_value("m_tvalid_o in reset", 0, int'(m_tvalid_o));
    compare_value("abort_o in reset", 0, int'(abort_o));
    compare_value("level_o in reset", 0, int'(level_o));
    step();
    reset = 1'b0;
    step();
    compare_value("s_tready_o after reset", 1, int'(s_tready_o));
    finish_test();

    for (int r = 0; r < n_rec; r++) begin
      op    = recs[r][15:12];
      flags = recs[r][11:8];
      data  = recs[r][7:0];
      case (op)
        4'h1: send_beat(flags[0], flags[1], data);
        4'h2: respond(1'b0, 1'b0);
        4'h3: respond(1'b1, 1'b0);
        4'h4: expect_word(flags[1], data);
        4'h5: respond(1'b1, 1'b1);
        4'h6: expect_level(flags[0], data);
        4'h7: stall = flags[0];
        4'hF: finish_test();
        default: begin
          $display("Pattern record %0d has an unknown opcode %0h", r, op);
          errors++;
        end
      endcase
    end

    assert (n_rec > 0) else begin
      $display("The pattern file held no records");
      errors++;
    end
    assert (out_q.size() == 0) else begin
      $display("The DUT sent %0d output words that no record expected", out_q.size());
      errors++;
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             test_idx, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/link_patterns.mem */
// Columns: opcode_flags_byte. 1 beat (flags bit0 keep, bit1 last), 2 ack, 3 nak with replay,
// 4 expected output word (flags bit1 last), 5 nak with abort, 6 expected level (flags bit0
// s_tready), 7 output ready mode (flags 1 held low), F end of test
// Test 1: payload 01 02 with trailer 1B
1_1_01
1_1_02
1_3_1B
4_0_01
4_0_02
4_2_1B
2_0_00
F_0_00
// Test 2: trailer 08 is wrong and the frame is dropped, 01 07 follows
1_1_01
1_3_08
1_1_01
1_3_07
4_0_01
4_2_07
2_0_00
F_0_00
// Test 3: 55 with keep low is not stored
1_1_01
1_0_55
1_3_07
4_0_01
4_2_07
2_0_00
F_0_00
// Test 4: 02 0E is replayed after a nak, 08 38 follows the ack
1_1_02
1_3_0E
1_1_08
1_3_38
4_0_02
4_2_0E
3_0_00
4_0_02
4_2_0E
2_0_00
4_0_08
4_2_38
F_0_00
// Test 5: three more naks replay 08 38, the fourth aborts it
1_1_10
1_1_20
1_1_30
1_3_9C
3_0_00
4_0_08
4_2_38
3_0_00
4_0_08
4_2_38
3_0_00
4_0_08
4_2_38
5_0_00
4_0_10
4_0_20
4_0_30
4_2_9C
2_0_00
F_0_00
// Test 6: output held low, eight kept beats fill the FIFO
7_1_00
1_1_10
1_1_20
1_1_30
1_3_9C
6_1_04
1_1_10
1_1_20
1_0_AA
1_1_30
6_1_04
1_3_9C
6_0_08
F_0_00

/* tb.f */
source/stream_pkg.sv
source/link_ctrl_pkg.sv
source/crc8_check.sv
source/packet_fifo.sv
source/link_ctrl.sv
source/packet_link_top.sv
test/tb_packet_link.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the packet link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_packet_link -f tb.f -o tb_packet_link

out=$(./obj_dir/tb_packet_link)
echo "$out"
echo "$out" | grep -qx "All tests passed"
